// File: store_unit.f
+incdir+.
store_pkg.sv
store_decode.sv
store_rs.sv
store_agu.sv
store_result.sv
store_unit.sv
store_clock_gen.sv
store_unit_asserts.sv
store_unit_tb.sv

// File: run.sh
#!/bin/sh
# build the store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module store_unit_tb -f store_unit.f -o store_unit_sim

out=$(./obj_dir/store_unit_sim)
echo "$out"

# the run passes only when the pass line is present
echo "$out" | grep -q "^Finished with no errors$"

// File: store_unit_tb.sv
// directed testbench for the store issue subsystem with a store-queue responder
`timescale 1ns/10ps
`default_nettype none
`include "store_macros.svh"

module store_unit_tb;

    logic                   clock;
    logic                   arst_n;
    logic                   flush;
    logic                   dispatch_valid;
    logic                   full;
    logic                   sq_req;
    logic                   sq_ack;
    logic                   ack_hold;     // responder withholds acknowledgements
    logic                   delay_armed;
    int                     ack_delay;
    int                     errors;
    int                     test_errors;
    int                     checks;
    int                     tests;
    store_pkg::store_inst_t dispatch;
    store_pkg::cdb_t        cdb;
    store_pkg::sq_write_t   sq_write;
    store_pkg::sq_write_t   got[$];       // every write the store queue accepted

    store_clock_gen clkgen0 (.clock(clock), .arst_n(arst_n));

    store_unit dut0 (
        .clock(clock), .arst_n(arst_n), .flush(flush),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch), .cdb(cdb),
        .full(full), .sq_req(sq_req), .sq_write(sq_write), .sq_ack(sq_ack)
    );

    //////////////////////////////////////////////////
    // store-queue responder

    task automatic respond_step();
        if (!arst_n) begin
            sq_ack      = 1'b0;
            delay_armed = 1'b0;
        end else if (sq_ack) begin
            if (!sq_req) sq_ack = 1'b0;   // close the four-phase cycle
        end else if (sq_req && !ack_hold) begin
            if (!delay_armed) begin
                ack_delay   = $urandom % 4;
                delay_armed = 1'b1;
            end
            if (ack_delay == 0) begin
                got.push_back(sq_write);
                sq_ack      = 1'b1;
                delay_armed = 1'b0;
            end else begin
                ack_delay--;
            end
        end
    endtask

    always @(posedge clock) begin
        #1;
        respond_step();
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    task automatic check_write(input string name, input store_pkg::sq_write_t got_w,
                               input store_pkg::sq_write_t exp_w);
        checks++;
        if (got_w !== exp_w) begin
            $display("Error: %s got %h expected %h", name, got_w, exp_w);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got_b, input logic exp_b);
        checks++;
        if (got_b !== exp_b) begin
            $display("Error: %s got %h expected %h", name, got_b, exp_b);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) $display("test %s passed", name);
        else $display("test %s failed with %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    // waiting operands carry their preg index in the low bits of base or src
    function automatic store_pkg::store_inst_t make_store(
        input logic [2:0] funct3, input logic [11:0] imm, input logic base_rdy,
        input logic [31:0] base, input logic src_rdy, input logic [31:0] src, input int tag);
        store_pkg::store_inst_t s;
        s            = '0;
        s.inst       = {imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], 7'b0100011};
        s.pc         = 32'h100 + 32'(tag) * 4;
        s.rob_idx    = 5'(tag);
        s.sq_idx     = 3'(tag);
        s.base_ready = base_rdy;
        s.base_preg  = base_rdy ? 6'd1 : base[5:0];
        s.base_value = base_rdy ? base : 32'h0;
        s.src_ready  = src_rdy;
        s.src_preg   = src_rdy ? 6'd1 : src[5:0];
        s.src_value  = src_rdy ? src : 32'h0;
        return s;
    endfunction

    function automatic store_pkg::sq_write_t expected_write(
        input logic [2:0] funct3, input logic [11:0] imm, input logic [31:0] base,
        input logic [31:0] src, input int tag);
        store_pkg::sq_write_t w;
        int                   off;
        int                   nbytes;
        w.sq_idx    = 3'(tag);
        w.rob_idx   = 5'(tag);
        w.addr      = base + {{20{imm[11]}}, imm};
        off         = int'(w.addr[1:0]);
        nbytes      = (funct3 == 3'd0) ? 1 : (funct3 == 3'd1) ? 2 : 4;
        w.byte_mask = 4'b0000;
        for (int i = 0; i < 4; i++) begin
            if (nbytes == 4 || (i >= off && i < off + nbytes)) w.byte_mask[i] = 1'b1;
        end
        w.data       = src << (8 * off);
        w.misaligned = (off % nbytes) != 0;
        return w;
    endfunction

    task automatic dispatch_one(input store_pkg::store_inst_t inst);
        int t;
        t = 0;
        while (full && t < 50) begin
            step();
            t++;
        end
        if (full) begin
            report_failure("station stayed full, store could not be dispatched");
        end else begin
            dispatch       = inst;
            dispatch_valid = 1'b1;
            step();
            dispatch_valid = 1'b0;
        end
    endtask

    task automatic wait_writes(input int n, input int limit);
        int t;
        t = 0;
        while (got.size() < n && t < limit) begin
            step();
            t++;
        end
        if (got.size() < n) report_failure("timed out waiting for a store-queue write");
    endtask

    task automatic wait_req();
        int t;
        t = 0;
        while (!sq_req && t < 20) begin
            step();
            t++;
        end
        if (!sq_req) report_failure("timed out waiting for sq_req");
    endtask

    task automatic send_and_check(input logic [2:0] funct3, input logic [11:0] imm,
                                  input logic [31:0] base, input logic [31:0] src,
                                  input int tag);
        int n;
        n = got.size();
        dispatch_one(make_store(funct3, imm, 1'b1, base, 1'b1, src, tag));
        wait_writes(n + 1, 40);
        if (got.size() > n) begin
            check_write("sq_write", got[n], expected_write(funct3, imm, base, src, tag));
        end
    endtask

    //////////////////////////////////////////////////
    // tests

    task automatic test_ready_store();
        int edges;
        int n;
        n = got.size();
        dispatch_one(make_store(3'd2, 12'h024, 1'b1, 32'h0000_1000, 1'b1, 32'hdead_beef, 1));
        edges = 1;   // the dispatch edge itself
        while (!sq_req && edges < 10) begin
            step();
            edges++;
        end
        if (edges != 3) report_failure($sformatf("sq_req rose after %0d edges, not 3", edges));
        wait_writes(n + 1, 20);
        if (got.size() > n) begin
            check_write("sq_write", got[n],
                        expected_write(3'd2, 12'h024, 32'h0000_1000, 32'hdead_beef, 1));
        end
        end_test("ready store");
    endtask

    task automatic test_cdb_wakeup();
        int n;
        n = got.size();
        dispatch_one(make_store(3'd2, 12'h010, 1'b0, 32'd5, 1'b1, 32'hcafe_0001, 20));
        dispatch_one(make_store(3'd0, 12'hffc, 1'b1, 32'h4000_0003, 1'b0, 32'd9, 21));
        repeat (6) step();
        check_bit("sq_req", sq_req, 1'b0);
        cdb = '{valid: 1'b1, preg: 6'd5, value: 32'h3000_0000};
        step();
        cdb.valid = 1'b0;
        wait_writes(n + 1, 20);
        if (got.size() > n) check_write("sq_write", got[n],
            expected_write(3'd2, 12'h010, 32'h3000_0000, 32'hcafe_0001, 20));
        cdb = '{valid: 1'b1, preg: 6'd9, value: 32'h1234_56ab};
        step();
        cdb.valid = 1'b0;
        wait_writes(n + 2, 20);
        if (got.size() > n + 1) check_write("sq_write", got[n + 1],
            expected_write(3'd0, 12'hffc, 32'h4000_0003, 32'h1234_56ab, 21));
        // broadcast lands on the dispatch edge itself
        cdb = '{valid: 1'b1, preg: 6'd12, value: 32'h5000_0008};
        dispatch_one(make_store(3'd1, 12'h002, 1'b0, 32'd12, 1'b1, 32'h0000_beef, 22));
        cdb.valid = 1'b0;
        wait_writes(n + 3, 20);
        if (got.size() > n + 2) check_write("sq_write", got[n + 2],
            expected_write(3'd1, 12'h002, 32'h5000_0008, 32'h0000_beef, 22));
        end_test("cdb wakeup");
    endtask

    task automatic test_sizes();
        for (int f = 0; f < 3; f++) begin
            for (int off = 0; off < 4; off++) begin
                send_and_check(3'(f), 12'hff8, 32'h2000_0100 + 32'(off), $urandom, f * 4 + off);
            end
        end
        end_test("sizes and alignment");
    endtask

    task automatic test_backpressure();
        int n;
        n        = got.size();
        ack_hold = 1'b1;
        dispatch_one(make_store(3'd2, 12'h000, 1'b1, 32'h8000, 1'b1, 32'h1111_0000, 10));
        wait_req();
        dispatch_one(make_store(3'd2, 12'h004, 1'b1, 32'h8000, 1'b1, 32'h1111_0001, 11));
        repeat (4) step();   // second store now parked in the execute register
        for (int k = 2; k < `STORE_RS_DEPTH + 2; k++) begin
            dispatch_one(make_store(3'd2, 12'(k * 4), 1'b1, 32'h8000, 1'b1,
                                    32'h1111_0000 + 32'(k), 10 + k));
        end
        check_bit("full", full, 1'b1);
        ack_hold = 1'b0;
        wait_writes(n + `STORE_RS_DEPTH + 2, 300);
        repeat (10) step();
        if (got.size() != n + `STORE_RS_DEPTH + 2) begin
            report_failure($sformatf("expected %0d writes, saw %0d",
                                     `STORE_RS_DEPTH + 2, got.size() - n));
        end
        for (int k = 0; k < `STORE_RS_DEPTH + 2; k++) begin
            if (n + k < got.size()) check_write("sq_write", got[n + k],
                expected_write(3'd2, 12'(k * 4), 32'h8000, 32'h1111_0000 + 32'(k), 10 + k));
        end
        end_test("back-pressure and full");
    endtask

    task automatic test_flush();
        int n;
        n        = got.size();
        ack_hold = 1'b1;
        dispatch_one(make_store(3'd2, 12'h008, 1'b1, 32'h9000, 1'b1, 32'haaaa_0000, 24));
        wait_req();
        dispatch_one(make_store(3'd2, 12'h00c, 1'b1, 32'h9000, 1'b1, 32'haaaa_0001, 25));
        // this one ends up held in the issue register
        dispatch_one(make_store(3'd2, 12'h018, 1'b1, 32'h9000, 1'b1, 32'haaaa_0003, 29));
        repeat (4) step();
        dispatch_one(make_store(3'd2, 12'h010, 1'b0, 32'd20, 1'b1, 32'haaaa_0002, 26));
        dispatch_one(make_store(3'd2, 12'h014, 1'b1, 32'h9000, 1'b0, 32'd21, 27));
        flush = 1'b1;
        step();
        flush = 1'b0;
        cdb   = '{valid: 1'b1, preg: 6'd20, value: 32'h9100};
        step();
        cdb   = '{valid: 1'b1, preg: 6'd21, value: 32'h9200};
        step();
        cdb.valid = 1'b0;
        ack_hold  = 1'b0;
        wait_writes(n + 1, 20);
        repeat (12) step();
        if (got.size() != n + 1) begin
            report_failure($sformatf("expected 1 write across the flush, saw %0d",
                                     got.size() - n));
        end
        if (got.size() > n) check_write("sq_write", got[n],
            expected_write(3'd2, 12'h008, 32'h9000, 32'haaaa_0000, 24));
        check_bit("full", full, 1'b0);
        send_and_check(3'd0, 12'h001, 32'h9300, 32'h0000_0055, 28);
        end_test("flush");
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int t;
        void'($urandom(87352));
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb            = '0;
        sq_ack         = 1'b0;
        ack_hold       = 1'b0;
        delay_armed    = 1'b0;
        ack_delay      = 0;
        errors         = 0;
        test_errors    = 0;
        checks         = 0;
        tests          = 0;
        t              = 0;
        while (!arst_n && t < 20) begin
            step();
            t++;
        end
        if (!arst_n) report_failure("reset never released");
        check_bit("full", full, 1'b0);
        check_bit("sq_req", sq_req, 1'b0);
        end_test("reset");

        test_ready_store();
        test_cdb_wakeup();
        test_sizes();
        test_backpressure();
        test_flush();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: store_unit_asserts.sv
// handshake and station assertions for the store unit, bound into the design
`timescale 1ns/10ps
`default_nettype none

module store_unit_asserts (
    input logic                 clock,
    input logic                 arst_n,
    input logic                 sq_req,
    input logic                 sq_ack,
    input store_pkg::sq_write_t sq_write,
    input logic                 full,
    input logic                 dispatch_valid
);

    // payload frozen while the request waits for ack
    a_write_stable: assert property (@(posedge clock) disable iff (!arst_n)
        sq_req && !sq_ack |=> $stable(sq_write))
        else $error("sq_write changed during an open request");

    // ack level at the moment req went high
    a_req_rise: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(sq_req) |-> !$past(sq_ack))
        else $error("sq_req rose while sq_ack was still high");

    a_full_dispatch: assert property (@(posedge clock) disable iff (!arst_n)
        !(full && dispatch_valid))
        else $error("dispatch_valid asserted while the station was full");

endmodule

bind store_result store_unit_asserts result_asserts0 (
    .clock(clock), .arst_n(arst_n), .sq_req(sq_req), .sq_ack(sq_ack),
    .sq_write(sq_write), .full(1'b0), .dispatch_valid(1'b0)
);

bind store_rs store_unit_asserts rs_asserts0 (
    .clock(clock), .arst_n(arst_n), .sq_req(1'b0), .sq_ack(1'b0),
    .sq_write('0), .full(full), .dispatch_valid(dispatch_valid)
);

`default_nettype wire

// File: store_clock_gen.sv
// testbench clock and reset source, 8 ns clock and three cycles of reset
`timescale 1ns/10ps
`default_nettype none

module store_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock  = 1'b0;
        arst_n = 1'b0;
        repeat (3) @(posedge clock);
        #1 arst_n = 1'b1;
    end

    always #4 clock = ~clock;   // 8 ns period

endmodule

`default_nettype wire

// File: store_unit.sv
// store issue subsystem top, decode then station then execute then result
`timescale 1ns/10ps
`default_nettype none

module store_unit (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   dispatch_valid,
    input  store_pkg::store_inst_t dispatch,
    input  store_pkg::cdb_t        cdb,
    output logic                   full,
    output logic                   sq_req,
    output store_pkg::sq_write_t   sq_write,
    input  logic                   sq_ack
);

    store_pkg::store_entry_t entry;
    store_pkg::store_entry_t issue;
    store_pkg::sq_write_t    exec;
    logic                    issue_valid;
    logic                    issue_ready;
    logic                    exec_valid;
    logic                    exec_ready;

    store_decode decode0 (.inst(dispatch), .cdb(cdb), .entry(entry));

    store_rs rs0 (
        .clock(clock), .arst_n(arst_n), .flush(flush),
        .dispatch_valid(dispatch_valid), .entry(entry), .cdb(cdb),
        .issue_ready(issue_ready), .full(full),
        .issue_valid(issue_valid), .issue(issue)
    );

    store_agu agu0 (
        .clock(clock), .arst_n(arst_n), .flush(flush),
        .issue_valid(issue_valid), .issue(issue), .exec_ready(exec_ready),
        .issue_ready(issue_ready), .exec_valid(exec_valid), .exec(exec)
    );

    store_result result0 (
        .clock(clock), .arst_n(arst_n), .exec_valid(exec_valid), .exec(exec),
        .sq_ack(sq_ack), .exec_ready(exec_ready), .sq_req(sq_req), .sq_write(sq_write)
    );

endmodule

`default_nettype wire

// File: store_result.sv
// store result stage, four-phase req/ack delivery of writes to the store queue
`timescale 1ns/10ps
`default_nettype none

module store_result (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 exec_valid,
    input  store_pkg::sq_write_t exec,
    input  logic                 sq_ack,
    output logic                 exec_ready,
    output logic                 sq_req,
    output store_pkg::sq_write_t sq_write
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,        // req high, waiting for ack
        st_wait_low    // req dropped, waiting for ack to return low
    } state_t;

    state_t               state;
    state_t               state_next;
    store_pkg::sq_write_t held;
    logic                 take;

    // new write taken in idle, or in the cycle the handshake closes
    assign exec_ready = (state == st_idle) || (state == st_wait_low && !sq_ack);
    assign take       = exec_ready && exec_valid;

    assign sq_req   = (state == st_req) || (state == st_idle && take);
    assign sq_write = (state == st_idle) ? exec : held;

    always_comb begin
        state_next = state;
        case (state)
            st_idle:     if (take) state_next = sq_ack ? st_wait_low : st_req;   // ack may come at once
            st_req:      if (sq_ack) state_next = st_wait_low;
            st_wait_low: if (!sq_ack) state_next = take ? st_req : st_idle;
            default:     state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (take) held <= exec;   // stays put until acknowledged
    end

endmodule

`default_nettype wire

// File: store_agu.sv
// store execute stage, forms address, byte mask, lane-aligned data and misalign flag
`timescale 1ns/10ps
`default_nettype none

module store_agu (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    issue_valid,
    input  store_pkg::store_entry_t issue,
    input  logic                    exec_ready,
    output logic                    issue_ready,
    output logic                    exec_valid,
    output store_pkg::sq_write_t    exec
);

    store_pkg::xlen_t     addr;
    logic [1:0]           byte_off;
    store_pkg::sq_write_t exec_d;

    assign addr     = issue.base_value + issue.offset;
    assign byte_off = addr[1:0];

    // room when the register is empty or the result stage takes it this edge
    assign issue_ready = !exec_valid || exec_ready;

    always_comb begin
        exec_d.sq_idx  = issue.sq_idx;
        exec_d.rob_idx = issue.rob_idx;
        exec_d.addr    = addr;
        exec_d.data    = issue.src_value << {byte_off, 3'b000};   // move into byte lanes
        case (issue.mem_size)
            store_pkg::mem_byte: begin
                exec_d.byte_mask  = 4'b0001 << byte_off;
                exec_d.misaligned = 1'b0;
            end
            store_pkg::mem_half: begin
                exec_d.byte_mask  = 4'b0011 << byte_off;   // upper lane lost at offset 3
                exec_d.misaligned = byte_off[0];
            end
            default: begin
                exec_d.byte_mask  = 4'b1111;
                exec_d.misaligned = |byte_off;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            exec_valid <= 1'b0;
        end else if (flush) begin
            exec_valid <= 1'b0;
        end else if (issue_ready) begin
            exec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_ready && issue_valid) exec <= exec_d;   // held under back-pressure
    end

endmodule

`default_nettype wire

// File: store_rs.sv
// store reservation station, holds stores until base and data operands are ready
`timescale 1ns/10ps
`default_nettype none
`include "store_macros.svh"

module store_rs (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    dispatch_valid,
    input  store_pkg::store_entry_t entry,
    input  store_pkg::cdb_t         cdb,
    input  logic                    issue_ready,
    output logic                    full,
    output logic                    issue_valid,
    output store_pkg::store_entry_t issue
);

    localparam int DEPTH    = `STORE_RS_DEPTH;
    localparam int IDX_BITS = $clog2(DEPTH);

    store_pkg::store_entry_t slots [DEPTH];
    logic [DEPTH-1:0]        busy;
    logic [IDX_BITS:0]       count;
    logic [DEPTH-1:0]        ready;     // busy with both operands present
    logic [IDX_BITS-1:0]     free_idx;
    logic [IDX_BITS-1:0]     sel_idx;
    logic                    any_ready;
    logic                    do_dispatch;
    logic                    do_issue;

    assign full        = (count == (IDX_BITS+1)'(DEPTH));
    assign any_ready   = |ready;
    assign do_dispatch = dispatch_valid && !full;
    assign do_issue    = issue_ready && any_ready;

    //////////////////////////////////////////////////
    // slot selection

    // lowest free slot takes the next dispatch
    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) free_idx = IDX_BITS'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ready[i] = busy[i] && slots[i].base_ready && slots[i].src_ready;
        end
    end

    // oldest-slot issue, where oldest means lowest index
    always_comb begin
        sel_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) sel_idx = IDX_BITS'(i);
        end
    end

    //////////////////////////////////////////////////
    // control state

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy        <= '0;
            count       <= '0;
            issue_valid <= 1'b0;
        end else if (flush) begin
            busy        <= '0;   // mispredict kills every waiting store
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (do_dispatch) busy[free_idx] <= 1'b1;
            if (do_issue) busy[sel_idx] <= 1'b0;   // freed on the issuing edge
            count <= count + (IDX_BITS+1)'(do_dispatch) - (IDX_BITS+1)'(do_issue);
            if (issue_ready) begin
                issue_valid <= any_ready;
            end
        end
    end

    //////////////////////////////////////////////////
    // slot payload, cdb wakeup and issue register

    always_ff @(posedge clock) begin
        if (do_issue) issue <= slots[sel_idx];

        for (int i = 0; i < DEPTH; i++) begin
            if (busy[i] && cdb.valid) begin
                if (!slots[i].base_ready &&
                    store_pkg::preg_t'(slots[i].base_value) == cdb.preg) begin
                    slots[i].base_ready <= 1'b1;
                    slots[i].base_value <= cdb.value;
                end
                if (!slots[i].src_ready &&
                    store_pkg::preg_t'(slots[i].src_value) == cdb.preg) begin
                    slots[i].src_ready <= 1'b1;
                    slots[i].src_value <= cdb.value;
                end
            end
        end

        // free slot, so it never collides with a wakeup above
        if (do_dispatch) slots[free_idx] <= entry;
    end

endmodule

`default_nettype wire

// File: store_decode.sv
// store decode, turns a dispatched instruction word into a station entry
`timescale 1ns/10ps
`default_nettype none

module store_decode (
    input  store_pkg::store_inst_t  inst,
    input  store_pkg::cdb_t         cdb,
    output store_pkg::store_entry_t entry
);

    logic [2:0] funct3;
    logic       base_hit;   // cdb delivers the base operand this cycle
    logic       src_hit;

    assign funct3 = inst.inst[14:12];

    // same-cycle bypass so a broadcast is not missed while the slot is written
    assign base_hit = cdb.valid && !inst.base_ready && (cdb.preg == inst.base_preg);
    assign src_hit  = cdb.valid && !inst.src_ready && (cdb.preg == inst.src_preg);

    always_comb begin
        case (funct3)
            3'd0:    entry.mem_size = store_pkg::mem_byte;
            3'd1:    entry.mem_size = store_pkg::mem_half;
            default: entry.mem_size = store_pkg::mem_word;   // sw and anything unknown
        endcase

        // s-type immediate is split over imm[11:5] and imm[4:0]
        entry.offset  = store_pkg::xlen_t'($signed({inst.inst[31:25], inst.inst[11:7]}));
        entry.rob_idx = inst.rob_idx;
        entry.sq_idx  = inst.sq_idx;

        entry.base_ready = inst.base_ready || base_hit;
        if (inst.base_ready) begin
            entry.base_value = inst.base_value;
        end else if (base_hit) begin
            entry.base_value = cdb.value;
        end else begin
            entry.base_value = store_pkg::xlen_t'(inst.base_preg);   // tag to wait on
        end

        entry.src_ready = inst.src_ready || src_hit;
        if (inst.src_ready) begin
            entry.src_value = inst.src_value;
        end else if (src_hit) begin
            entry.src_value = cdb.value;
        end else begin
            entry.src_value = store_pkg::xlen_t'(inst.src_preg);
        end
    end

endmodule

`default_nettype wire

// File: store_pkg.sv
// shared types for the store issue path, dispatch through store-queue write
`default_nettype none
`include "store_macros.svh"

package store_pkg;

    typedef logic [`STORE_XLEN-1:0]     xlen_t;
    typedef logic [`STORE_PRF_BITS-1:0] preg_t;
    typedef logic [`STORE_ROB_BITS-1:0] rob_idx_t;
    typedef logic [`STORE_SQ_BITS-1:0]  sq_idx_t;

    // access size, encoded like the low bits of funct3
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_t;

    // one store as it leaves dispatch, operands already looked up in the prf
    typedef struct packed {
        logic [31:0] inst;
        xlen_t       pc;
        rob_idx_t    rob_idx;
        sq_idx_t     sq_idx;
        preg_t       base_preg;
        logic        base_ready;
        xlen_t       base_value;
        preg_t       src_preg;
        logic        src_ready;
        xlen_t       src_value;
    } store_inst_t;

    // station slot; a value field holds the preg index while not ready
    typedef struct packed {
        mem_size_t mem_size;
        xlen_t     offset;
        rob_idx_t  rob_idx;
        sq_idx_t   sq_idx;
        logic      base_ready;
        xlen_t     base_value;
        logic      src_ready;
        xlen_t     src_value;
    } store_entry_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
        xlen_t value;
    } cdb_t;

    typedef struct packed {
        sq_idx_t    sq_idx;
        rob_idx_t   rob_idx;
        xlen_t      addr;
        xlen_t      data;
        logic [3:0] byte_mask;
        logic       misaligned;
    } sq_write_t;

endpackage

`default_nettype wire

// File: store_macros.svh
// store issue subsystem sizing constants shared by rtl and testbench
`ifndef STORE_MACROS_SVH
`define STORE_MACROS_SVH

// reservation station slots, one word of entries
`define STORE_RS_DEPTH 8

// index widths coming from rename, rob and store queue
`define STORE_PRF_BITS 6
`define STORE_ROB_BITS 5
`define STORE_SQ_BITS  3

// architectural data width
`define STORE_XLEN 32

`endif
